// ==== source/vic_cfg.svh ====
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// --------------------------------------------------
// phase timing
// --------------------------------------------------

// clocks of clk_dot4x per PHI half-phase
`define VIC_PHASE_TICKS 16

// tick in the low phase that moves the delayed line and the bad line
`define VIC_LINE_TICK 1

// tick in the low phase where the raster compare is sampled
`define VIC_IRQ_CHECK_TICK 8

// --------------------------------------------------
// bad-line window
// --------------------------------------------------

// first line that may be a bad line, also where den is latched
`define VIC_BADLINE_FIRST 48

// first line past the window, clears the allow latch
`define VIC_BADLINE_LAST 248

// --------------------------------------------------
// bus arbitration
// --------------------------------------------------

// PHI high phases between ba falling and aec held low
`define VIC_BA_CASCADE 3

`endif

// ==== source/vic_chip_pkg.sv ====
`default_nettype none

package vic_chip_pkg;

    // chip select as strapped on the board
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569     = 2'd2,
        CHIP_UNUSED   = 2'd3
    } chip_t;

    // per-chip raster geometry and c-access ba window
    typedef struct packed {
        logic [9:0] raster_x_max;
        logic [8:0] raster_y_max;
        logic [9:0] chars_ba_start;
        logic [9:0] chars_ba_end;
    } raster_limits_t;

    // limits lookup, unused code falls back to pal
    function automatic raster_limits_t chip_limits(input chip_t chip);
        raster_limits_t lim;
        case (chip)
            CHIP_6567R8: begin
                // 65 cycles, 263 lines
                lim = '{10'd519, 9'd262, 10'h1f4, 10'h14c};
            end
            CHIP_6567R56A: begin
                // 64 cycles, 262 lines
                lim = '{10'd511, 9'd261, 10'h1f4, 10'h14c};
            end
            default: begin
                // 6569 pal, 63 cycles, 312 lines
                lim = '{10'd503, 9'd311, 10'h1ec, 10'h14c};
            end
        endcase
        return lim;
    endfunction

endpackage : vic_chip_pkg

`default_nettype wire

// ==== source/vic_timing_pkg.sv ====
`default_nettype none

package vic_timing_pkg;

    // --------------------------------------------------
    // raster coordinates
    // --------------------------------------------------

    // pixel position within a line, widest chip needs 520
    typedef logic [9:0] raster_x_t;

    // line number, pal needs 312
    typedef logic [8:0] raster_line_t;

    // raster_x / 8, one cycle per 8 pixels
    typedef logic [6:0] cycle_num_t;

    // --------------------------------------------------
    // strobes
    // --------------------------------------------------

    // one-hot tick within the current PHI half-phase
    // bit 15 set means PHI toggles on the next clock
    typedef logic [15:0] phase_strobe_t;

    // one-hot tick within a pixel
    // bit 0 is the last tick of the pixel
    typedef logic [3:0] dot_strobe_t;

endpackage : vic_timing_pkg

`default_nettype wire

// ==== source/vic_clock_phase.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_clock_phase (
    input  wire                           clk_dot4x,
    input  wire                           rst,
    output logic                          clk_phi_o,
    output vic_timing_pkg::phase_strobe_t phase_strobe_o,
    output vic_timing_pkg::dot_strobe_t   dot_strobe_o
);

    localparam int phi_bits = 2 * `VIC_PHASE_TICKS;

    // reset alignment: PHI low and a quarter into its phase
    // bits 4..19 form the high half, bit 0 drives PHI
    localparam logic [phi_bits-1:0] phi_rst = 32'h000f_fff0;

    logic [phi_bits-1:0] phi_gen;

    // --------------------------------------------------
    // rotators
    // --------------------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_gen        <= phi_rst;
            phase_strobe_o <= 16'h0008;
            dot_strobe_o   <= 4'b1000;
        end else begin
            // all three rotate left by one each clock
            phi_gen        <= {phi_gen[phi_bits-2:0], phi_gen[phi_bits-1]};
            phase_strobe_o <= {phase_strobe_o[14:0], phase_strobe_o[15]};
            dot_strobe_o   <= {dot_strobe_o[2:0], dot_strobe_o[3]};
        end
    end

    assign clk_phi_o = phi_gen[0];

    // PHI toggles right after tick 15 and every fourth tick ends a pixel
    a_strobes_aligned : assert property (@(posedge clk_dot4x) disable iff (rst)
        (phase_strobe_o[`VIC_PHASE_TICKS-1] == (phi_gen[phi_bits-1] != phi_gen[0])) &&
        (dot_strobe_o[0] == |{phase_strobe_o[12], phase_strobe_o[8],
                               phase_strobe_o[4], phase_strobe_o[0]}));

endmodule : vic_clock_phase

`default_nettype wire

// ==== source/vic_raster_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_raster_counter (
    input  wire                           clk_dot4x,
    input  wire                           rst,
    input  vic_chip_pkg::chip_t           chip_i,
    input  wire                           clk_phi_i,
    input  vic_timing_pkg::phase_strobe_t phase_strobe_i,
    input  vic_timing_pkg::dot_strobe_t   dot_strobe_i,
    output vic_timing_pkg::raster_x_t     raster_x_o,
    output vic_timing_pkg::raster_line_t  raster_line_o,
    output vic_timing_pkg::raster_line_t  raster_line_d_o,
    output vic_timing_pkg::cycle_num_t    cycle_num_o
);

    vic_chip_pkg::raster_limits_t lim;

    // chip only changes under reset, so the lookup is static in practice
    assign lim = vic_chip_pkg::chip_limits(chip_i);

    // --------------------------------------------------
    // pixel and line counters
    // --------------------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_o    <= '0;
            raster_line_o <= '0;
        end else if (dot_strobe_i[0]) begin
            // one pixel per four clocks
            if (raster_x_o == lim.raster_x_max) begin
                raster_x_o <= '0;
                // end of line, step or wrap the line
                if (raster_line_o == lim.raster_y_max) begin
                    raster_line_o <= '0;
                end else begin
                    raster_line_o <= raster_line_o + 9'd1;
                end
            end else begin
                raster_x_o <= raster_x_o + 10'd1;
            end
        end
    end

    // delayed line, moves once per cycle early in the low phase
    // irq compare and bad-line latch look at this copy
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line_d_o <= '0;
        end else if (!clk_phi_i && phase_strobe_i[`VIC_LINE_TICK]) begin
            raster_line_d_o <= raster_line_o;
        end
    end

    // 8 pixels per cycle
    assign cycle_num_o = raster_x_o[9:3];

    a_x_in_range : assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x_o <= lim.raster_x_max);

endmodule : vic_raster_counter

`default_nettype wire

// ==== source/vic_badline_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_badline_detect (
    input  wire                           clk_dot4x,
    input  wire                           rst,
    input  wire                           clk_phi_i,
    input  vic_timing_pkg::phase_strobe_t phase_strobe_i,
    input  vic_timing_pkg::raster_line_t  raster_line_i,
    input  vic_timing_pkg::raster_line_t  raster_line_d_i,
    input  vic_timing_pkg::cycle_num_t    cycle_num_i,
    input  logic                          den_i,
    input  logic [2:0]                    yscroll_i,
    output logic                          badline_o
);

    logic line_tick;
    logic allow_bad_lines;
    logic allow_set;
    logic allow_nxt;
    logic in_window;

    // once per cycle, low phase
    assign line_tick = !clk_phi_i && phase_strobe_i[`VIC_LINE_TICK];

    // --------------------------------------------------
    // allow latch
    // --------------------------------------------------

    // den seen on line 48: current line catches cycle 0,
    // delayed line still reads 48 on the last cycle before the line steps
    assign allow_set = den_i &&
        ((raster_line_i == 9'(`VIC_BADLINE_FIRST) && cycle_num_i == 7'd0) ||
         raster_line_d_i == 9'(`VIC_BADLINE_FIRST));

    // clear wins on line 248
    assign allow_nxt = (allow_bad_lines || allow_set) &&
        (raster_line_i != 9'(`VIC_BADLINE_LAST));

    assign in_window = (raster_line_i >= 9'(`VIC_BADLINE_FIRST)) &&
        (raster_line_i < 9'(`VIC_BADLINE_LAST));

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline_o       <= 1'b0;
        end else if (line_tick) begin
            allow_bad_lines <= allow_nxt;
            // bad line uses the already updated latch
            badline_o <= (raster_line_i[2:0] == yscroll_i) && allow_nxt && in_window;
        end
    end

    // delayed line moves on the same tick, so it names the line badline was decided on
    a_badline_window : assert property (@(posedge clk_dot4x) disable iff (rst)
        badline_o |-> (raster_line_d_i >= 9'(`VIC_BADLINE_FIRST) &&
                       raster_line_d_i < 9'(`VIC_BADLINE_LAST)));

endmodule : vic_badline_detect

`default_nettype wire

// ==== source/vic_raster_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_raster_irq (
    input  wire                           clk_dot4x,
    input  wire                           rst,
    input  wire                           clk_phi_i,
    input  vic_timing_pkg::phase_strobe_t phase_strobe_i,
    input  vic_timing_pkg::raster_line_t  raster_line_d_i,
    input  vic_timing_pkg::raster_line_t  raster_irq_compare_i,
    input  logic                          irq_clr_i,
    output logic                          irq_o
);

    vic_timing_pkg::raster_line_t compare_d;
    logic triggered;
    logic match;
    logic check_tick;

    // compare value is lined up one clock behind the register write
    always_ff @(posedge clk_dot4x) begin
        compare_d <= raster_irq_compare_i;
    end

    assign match      = (raster_line_d_i == compare_d);
    assign check_tick = !clk_phi_i && phase_strobe_i[`VIC_IRQ_CHECK_TICK];

    // --------------------------------------------------
    // latch and per-line trigger flag
    // --------------------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq_o     <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (match) begin
                // fire once, flag holds until the values differ
                if (check_tick && !triggered) begin
                    triggered <= 1'b1;
                    irq_o     <= 1'b1;
                end
            end else begin
                triggered <= 1'b0;
            end
            // clear from the cpu side beats a set
            if (irq_clr_i) begin
                irq_o <= 1'b0;
            end
        end
    end

endmodule : vic_raster_irq

`default_nettype wire

// ==== source/vic_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_bus_arbiter (
    input  wire                           clk_dot4x,
    input  wire                           rst,
    input  vic_chip_pkg::chip_t           chip_i,
    input  wire                           clk_phi_i,
    input  vic_timing_pkg::phase_strobe_t phase_strobe_i,
    input  vic_timing_pkg::raster_x_t     raster_x_i,
    input  logic                          badline_i,
    output logic                          ba_o,
    output logic                          aec_o
);

    localparam int depth = `VIC_BA_CASCADE;

    vic_chip_pkg::raster_limits_t lim;
    logic chars_window;
    logic phi_end;
    // ba delayed by whole PHI periods, top bit gates aec
    logic [depth-1:0] ba_casc;

    assign lim = vic_chip_pkg::chip_limits(chip_i);

    // --------------------------------------------------
    // c-access window
    // --------------------------------------------------

    // window wraps past the end of the line, hence the or
    assign chars_window = badline_i &&
        (raster_x_i >= lim.chars_ba_start || raster_x_i < lim.chars_ba_end);

    // ba is active low, low while chars are fetched
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b1;
        end else begin
            ba_o <= !chars_window;
        end
    end

    // last tick of the high phase
    assign phi_end = clk_phi_i && phase_strobe_i[`VIC_PHASE_TICKS-1];

    // cascade so the cpu keeps aec for three more high phases
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_casc <= '1;
        end else if (phi_end) begin
            ba_casc[0] <= ba_o;
            for (int i = 1; i < depth; i++) begin
                ba_casc[i] <= ba_casc[i-1] | ba_o;
            end
        end
    end

    // aec follows PHI unless the stolen cycle has reached the end of the cascade
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            aec_o <= 1'b0;
        end else begin
            aec_o <= ba_o ? clk_phi_i : (ba_casc[depth-1] & clk_phi_i);
        end
    end

    // a new ba request finds the cascade full and the cpu keeps three more high phases
    a_cascade_full_on_request : assert property (@(posedge clk_dot4x) disable iff (rst)
        $fell(ba_o) |-> ba_casc[depth-1]);

endmodule : vic_bus_arbiter

`default_nettype wire

// ==== source/vic_raster_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module vic_raster_core (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  vic_chip_pkg::chip_t          chip_i,
    input  logic                         den_i,
    input  logic [2:0]                   yscroll_i,
    input  vic_timing_pkg::raster_line_t raster_irq_compare_i,
    input  logic                         irq_clr_i,
    output logic                         clk_phi_o,
    output vic_timing_pkg::raster_x_t    raster_x_o,
    output vic_timing_pkg::raster_line_t raster_line_o,
    output logic                         badline_o,
    output logic                         irq_o,
    output logic                         ba_o,
    output logic                         aec_o
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------

    logic                          clk_phi;
    vic_timing_pkg::phase_strobe_t phase_strobe;
    vic_timing_pkg::dot_strobe_t   dot_strobe;
    vic_timing_pkg::raster_x_t     raster_x;
    vic_timing_pkg::raster_line_t  raster_line;
    // line as seen by irq and bad-line logic
    vic_timing_pkg::raster_line_t  raster_line_d;
    vic_timing_pkg::cycle_num_t    cycle_num;
    logic                          badline;

    // PHI and strobes
    vic_clock_phase u_clock_phase (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .clk_phi_o      (clk_phi),
        .phase_strobe_o (phase_strobe),
        .dot_strobe_o   (dot_strobe)
    );

    // x/y position
    vic_raster_counter u_raster_counter (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .chip_i          (chip_i),
        .clk_phi_i       (clk_phi),
        .phase_strobe_i  (phase_strobe),
        .dot_strobe_i    (dot_strobe),
        .raster_x_o      (raster_x),
        .raster_line_o   (raster_line),
        .raster_line_d_o (raster_line_d),
        .cycle_num_o     (cycle_num)
    );

    vic_badline_detect u_badline_detect (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .clk_phi_i       (clk_phi),
        .phase_strobe_i  (phase_strobe),
        .raster_line_i   (raster_line),
        .raster_line_d_i (raster_line_d),
        .cycle_num_i     (cycle_num),
        .den_i           (den_i),
        .yscroll_i       (yscroll_i),
        .badline_o       (badline)
    );

    vic_raster_irq u_raster_irq (
        .clk_dot4x            (clk_dot4x),
        .rst                  (rst),
        .clk_phi_i            (clk_phi),
        .phase_strobe_i       (phase_strobe),
        .raster_line_d_i      (raster_line_d),
        .raster_irq_compare_i (raster_irq_compare_i),
        .irq_clr_i            (irq_clr_i),
        .irq_o                (irq_o)
    );

    // ba/aec toward the cpu
    vic_bus_arbiter u_bus_arbiter (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip_i),
        .clk_phi_i      (clk_phi),
        .phase_strobe_i (phase_strobe),
        .raster_x_i     (raster_x),
        .badline_i      (badline),
        .ba_o           (ba_o),
        .aec_o          (aec_o)
    );

    assign clk_phi_o     = clk_phi;
    assign raster_x_o    = raster_x;
    assign raster_line_o = raster_line;
    assign badline_o     = badline;

endmodule : vic_raster_core

`default_nettype wire

// ==== sim/tb_vic_model.svh ====
`ifndef TB_VIC_MODEL_SVH
`define TB_VIC_MODEL_SVH

// --------------------------------------------------
// reference model, one update per rising edge
// --------------------------------------------------

logic m_phi;
int   m_tick;
int   m_dot;
int   m_x;
int   m_line;
int   m_line_d;
logic m_allow;
logic m_badline;
int   m_cmp_d;
logic m_trig;
logic m_irq;
logic m_ba;
logic m_ba1;
logic m_ba2;
logic m_ba3;
logic m_aec;

// raster geometry and c-access window per chip
task automatic model_limits(input vic_chip_pkg::chip_t chip, output int x_max,
                            output int y_max, output int ba_start, output int ba_end);
    ba_end = 'h14c;
    case (chip)
        vic_chip_pkg::CHIP_6567R8: begin
            x_max    = 519;
            y_max    = 262;
            ba_start = 'h1f4;
        end
        vic_chip_pkg::CHIP_6567R56A: begin
            x_max    = 511;
            y_max    = 261;
            ba_start = 'h1f4;
        end
        default: begin
            // 6569, unused code behaves the same
            x_max    = 503;
            y_max    = 311;
            ba_start = 'h1ec;
        end
    endcase
endtask

// updates go in reverse dependency order so each rule sees pre-edge values
task automatic model_step(input logic rst_v, input vic_chip_pkg::chip_t chip, input logic den,
                          input logic [2:0] ys, input int cmp, input logic clr);
    int   x_max;
    int   y_max;
    int   ba_start;
    int   ba_end;
    logic line_tick;
    logic irq_tick;
    logic phi_end;
    model_limits(chip, x_max, y_max, ba_start, ba_end);
    line_tick = !m_phi && (m_tick == `VIC_LINE_TICK);
    irq_tick  = !m_phi && (m_tick == `VIC_IRQ_CHECK_TICK);
    phi_end   = m_phi && (m_tick == `VIC_PHASE_TICKS - 1);
    if (rst_v) begin
        // PHI low, a quarter into the half-phase
        m_phi     = 1'b0;
        m_tick    = 3;
        m_dot     = 3;
        m_x       = 0;
        m_line    = 0;
        m_line_d  = 0;
        m_allow   = 1'b0;
        m_badline = 1'b0;
        m_trig    = 1'b0;
        m_irq     = 1'b0;
        m_ba      = 1'b1;
        m_ba1     = 1'b1;
        m_ba2     = 1'b1;
        m_ba3     = 1'b1;
        m_aec     = 1'b0;
        m_cmp_d   = cmp;
        return;
    end
    // aec, then cascade top down, then ba
    m_aec = m_ba ? m_phi : (m_ba3 && m_phi);
    if (phi_end) begin
        m_ba3 = m_ba2 || m_ba;
        m_ba2 = m_ba1 || m_ba;
        m_ba1 = m_ba;
    end
    m_ba = !(m_badline && (m_x >= ba_start || m_x < ba_end));
    // raster irq, fires once per matching line
    if (m_line_d == m_cmp_d) begin
        if (irq_tick && !m_trig) begin
            m_trig = 1'b1;
            m_irq  = 1'b1;
        end
    end else begin
        m_trig = 1'b0;
    end
    if (clr) begin
        m_irq = 1'b0;
    end
    m_cmp_d = cmp;
    // allow latch and bad line, once per cycle
    if (line_tick) begin
        if (den && ((m_line == `VIC_BADLINE_FIRST && m_x / 8 == 0) ||
                    m_line_d == `VIC_BADLINE_FIRST)) begin
            m_allow = 1'b1;
        end
        if (m_line == `VIC_BADLINE_LAST) begin
            m_allow = 1'b0;
        end
        m_badline = (m_line % 8 == ys) && m_allow &&
                    m_line >= `VIC_BADLINE_FIRST && m_line < `VIC_BADLINE_LAST;
        m_line_d = m_line;
    end
    // one pixel per dot period
    if (m_dot == 0) begin
        if (m_x == x_max) begin
            m_x    = 0;
            m_line = (m_line == y_max) ? 0 : m_line + 1;
        end else begin
            m_x = m_x + 1;
        end
    end
    // phase and dot position
    if (m_tick == `VIC_PHASE_TICKS - 1) begin
        m_phi = !m_phi;
    end
    m_tick = (m_tick + 1) % `VIC_PHASE_TICKS;
    m_dot  = (m_dot + 1) % 4;
endtask

`endif

// ==== sim/tb_vic_raster_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vic_cfg.svh"

module tb_vic_raster_core;

    logic                         clk_dot4x = 1'b0;
    logic                         rst;
    vic_chip_pkg::chip_t          chip_i;
    logic                         den_i;
    logic [2:0]                   yscroll_i;
    vic_timing_pkg::raster_line_t raster_irq_compare_i;
    logic                         irq_clr_i;
    logic                         clk_phi_o;
    vic_timing_pkg::raster_x_t    raster_x_o;
    vic_timing_pkg::raster_line_t raster_line_o;
    logic                         badline_o;
    logic                         irq_o;
    logic                         ba_o;
    logic                         aec_o;

    // run control
    logic [31:0]         rng_state = 32'h04fd_63e0;
    logic                want_rst;
    vic_chip_pkg::chip_t want_chip;
    // 0 den set late on line 48, 1 den never set, 2 den set from line 0
    int                  den_mode;
    int                  late_x;
    logic [2:0]          frame_ys;
    int                  last_line;
    int                  since_release;
    logic                phi_seen;

    `include "tb_vic_model.svh"

    vic_raster_core dut (
        .clk_dot4x            (clk_dot4x),
        .rst                  (rst),
        .chip_i               (chip_i),
        .den_i                (den_i),
        .yscroll_i            (yscroll_i),
        .raster_irq_compare_i (raster_irq_compare_i),
        .irq_clr_i            (irq_clr_i),
        .clk_phi_o            (clk_phi_o),
        .raster_x_o           (raster_x_o),
        .raster_line_o        (raster_line_o),
        .badline_o            (badline_o),
        .irq_o                (irq_o),
        .ba_o                 (ba_o),
        .aec_o                (aec_o)
    );

    initial begin
        forever #10 clk_dot4x = ~clk_dot4x;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    // upper half only, the low bits of an lcg repeat quickly
    function automatic logic [31:0] lcg_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, rng_state[31:16]};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic drive_inputs();
        int x_max;
        int y_max;
        int ba_start;
        int ba_end;
        model_limits(want_chip, x_max, y_max, ba_start, ba_end);
        rst       <= want_rst;
        chip_i    <= want_chip;
        yscroll_i <= frame_ys;
        if (want_rst) begin
            den_i                <= (den_mode == 2);
            raster_irq_compare_i <= 9'(lcg_rand() % (y_max + 1));
        end else if (den_mode == 0 && m_line == `VIC_BADLINE_FIRST && m_x == late_x) begin
            den_i <= 1'b1;
        end
        // now and then aim the compare a few lines ahead
        if (!want_rst && m_line != last_line && lcg_rand() % 4 == 0) begin
            raster_irq_compare_i <= 9'((m_line + 1 + lcg_rand() % 6) % (y_max + 1));
        end
        last_line = m_line;
        irq_clr_i <= (lcg_rand() % 64 == 0);
    endtask

    // model and drive on the rising edge, compare on the falling edge
    task automatic clock_step();
        @(posedge clk_dot4x);
        if (rst) begin
            since_release = 0;
            phi_seen      = 1'b0;
        end else begin
            since_release++;
        end
        model_step(rst, chip_i, den_i, yscroll_i, raster_irq_compare_i, irq_clr_i);
        drive_inputs();
        @(negedge clk_dot4x);
        check_value(clk_phi_o, m_phi, "clk_phi_o");
        check_value(raster_x_o, m_x, "raster_x_o");
        check_value(raster_line_o, m_line, "raster_line_o");
        check_value(badline_o, m_badline, "badline_o");
        check_value(irq_o, m_irq, "irq_o");
        check_value(ba_o, m_ba, "ba_o");
        check_value(aec_o, m_aec, "aec_o");
        if (clk_phi_o && !phi_seen) begin
            phi_seen = 1'b1;
            // reset leaves ticks 3 to 15 of the low half
            check_value(since_release, `VIC_PHASE_TICKS - 3, "clocks to first PHI rise");
        end
    endtask

    // --------------------------------------------------
    // one frame per chip, chip swapped under reset
    // --------------------------------------------------

    task automatic run_frame(input int run_idx, input vic_chip_pkg::chip_t chip);
        int x_max;
        int y_max;
        int ba_start;
        int ba_end;
        int n;
        model_limits(chip, x_max, y_max, ba_start, ba_end);
        want_rst  = 1'b1;
        want_chip = chip;
        den_mode  = run_idx;
        frame_ys  = 3'(lcg_rand());
        late_x    = 8 + lcg_rand() % 400;
        repeat (10) clock_step();
        want_rst = 1'b0;
        n = 0;
        while (raster_line_o == 0) begin
            clock_step();
            n++;
            if (n > 4 * (x_max + 1) + 64) begin
                fail_on_timeout("the raster line never left line 0");
            end
        end
        n = 0;
        while (raster_line_o != 0) begin
            clock_step();
            n++;
            if (n > 4 * (x_max + 1) * (y_max + 1)) begin
                fail_on_timeout("the frame never wrapped back to line 0");
            end
        end
    endtask

    initial begin
        int offset;
        rst                  = 1'b1;
        chip_i               = vic_chip_pkg::CHIP_6569;
        den_i                = 1'b0;
        yscroll_i            = 3'd0;
        raster_irq_compare_i = '0;
        irq_clr_i            = 1'b0;
        want_rst             = 1'b1;
        want_chip            = vic_chip_pkg::CHIP_6569;
        den_mode             = 1;
        late_x               = 0;
        frame_ys             = 3'd0;
        last_line            = 0;
        since_release        = 0;
        phi_seen             = 1'b0;
        // random chip order, every chip runs once
        offset = lcg_rand() % 3;
        for (int run = 0; run < 3; run++) begin
            run_frame(run, vic_chip_pkg::chip_t'(2'((offset + run) % 3)));
        end
        $display("Testbench passed");
        $finish;
    end

endmodule : tb_vic_raster_core

`default_nettype wire

// ==== vic_raster_core.f ====
+incdir+source
+incdir+sim
source/vic_chip_pkg.sv
source/vic_timing_pkg.sv
source/vic_clock_phase.sv
source/vic_raster_counter.sv
source/vic_badline_detect.sv
source/vic_raster_irq.sv
source/vic_bus_arbiter.sv
source/vic_raster_core.sv
sim/tb_vic_raster_core.sv

// ==== Bender.yml ====
package:
  name: vic_raster_core

sources:
  # design, packages first
  - include_dirs:
      - source
    files:
      - source/vic_chip_pkg.sv
      - source/vic_timing_pkg.sv
      - source/vic_clock_phase.sv
      - source/vic_raster_counter.sv
      - source/vic_badline_detect.sv
      - source/vic_raster_irq.sv
      - source/vic_bus_arbiter.sv
      - source/vic_raster_core.sv
  # testbench, top tb_vic_raster_core
  - target: simulation
    include_dirs:
      - source
      - sim
    files:
      - sim/tb_vic_raster_core.sv
